// File: verilog/mmio_config.svh
// MMIO client build constants
// Bus widths, register offsets, VPD bytes and reset values

`ifndef MMIO_CONFIG_SVH
`define MMIO_CONFIG_SVH

// Bus widths --------
`define MMIO_ADDR_WIDTH  8           // Host address incl. block select
`define MMIO_DATA_WIDTH  8
`define MMIO_OFS_WIDTH   7           // 128-byte register block

// Register offsets --------
`define VPD_ID           7'h00
`define VPD_VER          7'h01
`define VPD_REV          7'h02
`define PHY_STAT         7'h10
`define PHY_ETH0         7'h11       // Three bytes
`define LY2_MAC          7'h22       // Six bytes
`define LY3_IP           7'h34       // Four bytes
`define DIAG_SCRATCH     7'h70       // Four bytes
`define DIAG_CTRL        7'h74

// VPD contents, user bitstream
`define VPD_ID_VAL       8'h3C
`define VPD_VER_VAL      8'h01
`define VPD_REV_VAL      8'h00

// Reset values, lowest address in the low byte --------
`define ETH0_TUNING_RST  24'h05_05_41
`define MAC_ADDR_RST     48'h0
`define IP_ADDR_RST      32'h0
`define SCRATCH_RST      32'hEF_BE_AD_DE
`define DIAG_CTRL_RST    8'h00

`endif

// File: verilog/mmioBusPkg.sv
// Host bus side types
// One bus byte and the offset inside the register block

`include "mmio_config.svh"

package mmioBusPkg;

  // --------------------
  // Bus payload
  // --------------------
  typedef logic [`MMIO_DATA_WIDTH-1:0] mmioDataT;   // One data byte

  // Offset below the block select bit
  typedef logic [`MMIO_OFS_WIDTH-1:0] mmioOfsT;

endpackage

// File: verilog/mmioRegPkg.sv
// Register content types
// Tuning, diag control and status layouts, address payloads
// Byte 0 of each value sits at the lowest register address

`include "mmio_config.svh"

package mmioRegPkg;

  // PHY_ETH0 tuning, three bytes --------
  typedef struct packed {
    logic [2:0] rsvd2;              // Byte 2
    logic [4:0] txPostCursor;
    logic [2:0] rsvd1;              // Byte 1
    logic [4:0] txPreCursor;
    logic [3:0] txDriverSwing;      // Byte 0
    logic [2:0] rsvd0;
    logic       rxEqualizerMode;
  } eth0TuningT;

  // Loopback controls
  typedef struct packed {
    logic [4:0] rsvd;               // Kept and read back
    logic       macAddrSwapEn;
    logic       macLoopbackEn;
    logic       pcsLoopbackEn;
  } diagCtrlT;

  // Memory and Ethernet status, read only --------
  typedef struct packed {
    logic [3:0] zero;
    logic       eth0QpllLock;
    logic       eth0CoreReady;
    logic       mc1InitCalComplete;
    logic       mc0InitCalComplete;
  } phyStatusT;

  typedef logic [6*`MMIO_DATA_WIDTH-1:0] macAddrT;   // NTS0 MAC
  typedef logic [4*`MMIO_DATA_WIDTH-1:0] ipAddrT;    // NTS0 IPv4
  typedef logic [4*`MMIO_DATA_WIDTH-1:0] scratchT;   // Diag scratch

endpackage

// File: verilog/regBusIf.sv
// Internal register access bus
// Single-cycle write and read strobes with offset and data

`timescale 1ns/1ps

interface regBusIf
  import mmioBusPkg::*;
();

  logic     wrEn;    // Write strobe, one cycle
  logic     rdEn;    // Read strobe, never with wrEn
  mmioOfsT  ofs;     // Valid with a strobe
  mmioDataT wrData;

  // Bus port side
  modport requester (output wrEn, output rdEn, output ofs, output wrData);

  // Registers and read mux
  modport target (input wrEn, input rdEn, input ofs, input wrData);

endinterface

// File: verilog/emifPort.sv
// Host bus front end
// Samples chip select accesses, decodes the block select bit
// and issues one write or read strobe per access

`timescale 1ns/1ps
`include "mmio_config.svh"

module emifPort
  import mmioBusPkg::*;
(
  input  logic                        shlClk,
  input  logic                        rstN,
  input  logic                        csN,
  input  logic                        weN,       // Low for write
  input  logic [`MMIO_ADDR_WIDTH-1:0] addr,
  input  mmioDataT                    wrData,
  regBusIf.requester                  bus
);

  logic blockSel;   // Access to the lower half

  // --------------------
  // Address decode
  // --------------------
  // Upper half is unmapped and gives no strobe
  assign blockSel = !csN && !addr[`MMIO_ADDR_WIDTH-1];

  // Strobes one cycle after the access edge
  always_ff @(posedge shlClk or negedge rstN)
  begin
    if (!rstN)
    begin
      bus.wrEn <= 1'b0;
      bus.rdEn <= 1'b0;
    end
    else
    begin
      bus.wrEn <= blockSel && !weN;
      bus.rdEn <= blockSel &&  weN;
    end
  end

  // Offset and data ride along with the strobe
  always_ff @(posedge shlClk)
  begin
    if (!csN)
    begin
      bus.ofs    <= addr[`MMIO_OFS_WIDTH-1:0];   // Drop block select
      bus.wrData <= wrData;
    end
  end

endmodule

// File: verilog/ctrlReg.sv
// Byte-writable control register
// Payload of any packed type, mapped at BASE upward,
// lowest address to the least significant byte

`timescale 1ns/1ps
`include "mmio_config.svh"

module ctrlReg
  import mmioBusPkg::*;
#(
  parameter type     T     = logic [7:0],
  parameter mmioOfsT BASE  = '0,   // Offset of byte 0
  parameter T        RESET = '0
) (
  input  logic      shlClk,
  input  logic      rstN,
  regBusIf.target   bus,
  output T          value
);

  localparam int NumBytes = $bits(T) / `MMIO_DATA_WIDTH;

  logic [$bits(T)-1:0] valueQ;   // Raw byte lanes

  // --------------------
  // Lane write
  // --------------------
  always_ff @(posedge shlClk or negedge rstN)
  begin
    if (!rstN)
    begin
      valueQ <= RESET;
    end
    else if (bus.wrEn)
    begin
      for (int i = 0; i < NumBytes; i++)
      begin
        if (bus.ofs == mmioOfsT'(BASE + i))   // Addressed lane only
          valueQ[i*`MMIO_DATA_WIDTH +: `MMIO_DATA_WIDTH] <= bus.wrData;
      end
    end
  end

  // Back to the field layout
  assign value = T'(valueQ);

endmodule

// File: verilog/statusReadMux.sv
// Read side of the register block
// Selects VPD, live status or a control byte lane on a read strobe
// and returns it registered with a one-cycle valid

`timescale 1ns/1ps
`include "mmio_config.svh"

module statusReadMux
  import mmioBusPkg::*;
  import mmioRegPkg::*;
(
  input  logic       shlClk,
  input  logic       rstN,
  regBusIf.target    bus,
  input  phyStatusT  phyStatus,    // Live, shlClk domain
  input  eth0TuningT eth0Tuning,
  input  macAddrT    macAddr,
  input  ipAddrT     ipAddr,
  input  scratchT    scratch,
  input  diagCtrlT   diagCtrl,
  output mmioDataT   rdData,
  output logic       rdValid       // One cycle, no back-pressure
);

  mmioDataT rdByte;   // Selected before the output flop

  // Byte lane out of a value up to MAC size
  function automatic mmioDataT laneSel(input macAddrT vec, input int lane);
    return vec[lane*`MMIO_DATA_WIDTH +: `MMIO_DATA_WIDTH];
  endfunction

  // --------------------
  // Byte select
  // --------------------
  always_comb
  begin
    rdByte = '0;   // Unmapped reads as zero
    case (bus.ofs) inside
      `VPD_ID:   rdByte = `VPD_ID_VAL;     // Constant VPD
      `VPD_VER:  rdByte = `VPD_VER_VAL;
      `VPD_REV:  rdByte = `VPD_REV_VAL;
      `PHY_STAT: rdByte = phyStatus;
      [`PHY_ETH0 : `PHY_ETH0 + 7'd2]:
        rdByte = laneSel(48'(eth0Tuning), int'(bus.ofs - `PHY_ETH0));
      [`LY2_MAC : `LY2_MAC + 7'd5]:
        rdByte = laneSel(macAddr, int'(bus.ofs - `LY2_MAC));
      [`LY3_IP : `LY3_IP + 7'd3]:
        rdByte = laneSel(48'(ipAddr), int'(bus.ofs - `LY3_IP));
      [`DIAG_SCRATCH : `DIAG_SCRATCH + 7'd3]:
        rdByte = laneSel(48'(scratch), int'(bus.ofs - `DIAG_SCRATCH));
      `DIAG_CTRL: rdByte = diagCtrl;
      default:    rdByte = '0;
    endcase
  end

  // Output stage --------
  always_ff @(posedge shlClk or negedge rstN)
  begin
    if (!rstN)
      rdValid <= 1'b0;
    else
      rdValid <= bus.rdEn;   // Second cycle of read latency
  end

  always_ff @(posedge shlClk)
  begin
    if (bus.rdEn)
      rdData <= rdByte;   // Held until next read
  end

endmodule

// File: verilog/mmioClient.sv
// MMIO register client, top level
// Host bus front end, five control registers, read mux
// Status packing and control field fan-out to the shell

`timescale 1ns/1ps
`include "mmio_config.svh"

module mmioClient
  import mmioRegPkg::*;
(
  input  logic                        shlClk,
  input  logic                        rstN,
  // Host bus
  input  logic                        csN,
  input  logic                        weN,
  input  logic [`MMIO_ADDR_WIDTH-1:0] addr,
  input  logic [`MMIO_DATA_WIDTH-1:0] wrData,
  output logic [`MMIO_DATA_WIDTH-1:0] rdData,
  output logic                        rdValid,
  // Memory and Ethernet status
  input  logic                        mc0InitCalComplete,
  input  logic                        mc1InitCalComplete,
  input  logic                        eth0CoreReady,
  input  logic                        eth0QpllLock,
  // Transceiver tuning
  output logic                        eth0RxEqualizerMode,
  output logic [3:0]                  eth0TxDriverSwing,
  output logic [4:0]                  eth0TxPreCursor,
  output logic [4:0]                  eth0TxPostCursor,
  // Loopback controls
  output logic                        eth0PcsLoopbackEn,
  output logic                        eth0MacLoopbackEn,
  output logic                        eth0MacAddrSwapEn,
  // NTS0 addresses
  output logic [47:0]                 nts0MacAddress,
  output logic [31:0]                 nts0IpAddress
);

  phyStatusT  phyStatus;
  eth0TuningT eth0Tuning;
  macAddrT    macAddr;
  ipAddrT     ipAddr;
  scratchT    scratch;
  diagCtrlT   diagCtrl;

  regBusIf regBus ();   // Strobes from the bus port

  // --------------------
  // Front end
  // --------------------
  emifPort u_emifPort (
    .shlClk (shlClk),
    .rstN   (rstN),
    .csN    (csN),
    .weN    (weN),
    .addr   (addr),
    .wrData (wrData),
    .bus    (regBus.requester)
  );

  // Control registers --------
  ctrlReg #(.T(eth0TuningT), .BASE(`PHY_ETH0), .RESET(`ETH0_TUNING_RST)) u_eth0Tuning (
    .shlClk (shlClk), .rstN (rstN), .bus (regBus.target), .value (eth0Tuning));
  ctrlReg #(.T(macAddrT), .BASE(`LY2_MAC), .RESET(`MAC_ADDR_RST)) u_macAddr (
    .shlClk (shlClk), .rstN (rstN), .bus (regBus.target), .value (macAddr));
  ctrlReg #(.T(ipAddrT), .BASE(`LY3_IP), .RESET(`IP_ADDR_RST)) u_ipAddr (
    .shlClk (shlClk), .rstN (rstN), .bus (regBus.target), .value (ipAddr));
  ctrlReg #(.T(scratchT), .BASE(`DIAG_SCRATCH), .RESET(`SCRATCH_RST)) u_scratch (
    .shlClk (shlClk), .rstN (rstN), .bus (regBus.target), .value (scratch));
  ctrlReg #(.T(diagCtrlT), .BASE(`DIAG_CTRL), .RESET(`DIAG_CTRL_RST)) u_diagCtrl (
    .shlClk (shlClk), .rstN (rstN), .bus (regBus.target), .value (diagCtrl));

  // Read back
  statusReadMux u_readMux (
    .shlClk (shlClk), .rstN (rstN), .bus (regBus.target),
    .phyStatus (phyStatus), .eth0Tuning (eth0Tuning), .macAddr (macAddr),
    .ipAddr (ipAddr), .scratch (scratch), .diagCtrl (diagCtrl),
    .rdData (rdData), .rdValid (rdValid)
  );

  // --------------------
  // Status in, fields out
  // --------------------
  assign phyStatus = '{zero: 4'h0, eth0QpllLock: eth0QpllLock, eth0CoreReady: eth0CoreReady,
                       mc1InitCalComplete: mc1InitCalComplete,
                       mc0InitCalComplete: mc0InitCalComplete};

  assign eth0RxEqualizerMode = eth0Tuning.rxEqualizerMode;
  assign eth0TxDriverSwing   = eth0Tuning.txDriverSwing;
  assign eth0TxPreCursor     = eth0Tuning.txPreCursor;
  assign eth0TxPostCursor    = eth0Tuning.txPostCursor;
  assign eth0PcsLoopbackEn   = diagCtrl.pcsLoopbackEn;   // Reserved bits stay internal
  assign eth0MacLoopbackEn   = diagCtrl.macLoopbackEn;
  assign eth0MacAddrSwapEn   = diagCtrl.macAddrSwapEn;
  assign nts0MacAddress      = macAddr;
  assign nts0IpAddress       = ipAddr;

endmodule

// File: tb/mmioTbTasks.svh
// Host bus tasks for the MMIO client testbench
// Write, read with rdValid timeout, write followed by a read

`ifndef MMIO_TB_TASKS_SVH
`define MMIO_TB_TASKS_SVH

// Falling edges until rdValid, lat is -1 after maxWait
task automatic waitReadValid(input int maxWait, output logic [7:0] data, output int lat);
  int n;
  n    = 1;   // One edge already past the access
  lat  = -1;
  data = '0;
  while (lat < 0 && n <= maxWait)
  begin
    if (rdValid)
    begin
      lat  = n;
      data = rdData;   // Only valid in this cycle
    end
    else
    begin
      @(negedge shlClk);
      n++;
    end
  end
endtask

task automatic busWrite(input logic [7:0] a, input logic [7:0] data);
  @(negedge shlClk);
  csN    = 1'b0;
  weN    = 1'b0;
  addr   = a;
  wrData = data;
  @(negedge shlClk);
  csN = 1'b1;
  weN = 1'b1;
  @(negedge shlClk);   // Control outputs move one edge later
endtask

task automatic busRead(input logic [7:0] a, input int maxWait,
                       output logic [7:0] data, output int lat);
  @(negedge shlClk);
  csN  = 1'b0;
  weN  = 1'b1;
  addr = a;
  @(negedge shlClk);
  csN = 1'b1;
  waitReadValid(maxWait, data, lat);
endtask

// Write at one access edge, read the same offset at the next
task automatic writeThenRead(input logic [7:0] a, input logic [7:0] wr,
                             output logic [7:0] data, output int lat);
  @(negedge shlClk);
  csN    = 1'b0;
  weN    = 1'b0;
  addr   = a;
  wrData = wr;
  @(negedge shlClk);
  weN = 1'b1;   // Now a read
  @(negedge shlClk);
  csN = 1'b1;
  waitReadValid(ReadTimeout, data, lat);
endtask

`endif

// File: tb/tbMmioClient.sv
// Testbench for the MMIO register client
// Clock and reset, six directed tests, rdValid assertions

`timescale 1ns/1ps
`include "mmio_config.svh"

module tbMmioClient;

  localparam int ReadTimeout = 8;        // Falling edges per read
  localparam int ReadLatency = 2;        // Access drive to rdValid
  localparam int WatchdogNs  = 200000;

  logic        shlClk, rstN, csN, weN, rdValid;
  logic [7:0]  addr, wrData, rdData;
  logic        mc0InitCalComplete, mc1InitCalComplete, eth0CoreReady, eth0QpllLock;
  logic        eth0RxEqualizerMode, eth0PcsLoopbackEn, eth0MacLoopbackEn, eth0MacAddrSwapEn;
  logic [3:0]  eth0TxDriverSwing;
  logic [4:0]  eth0TxPreCursor, eth0TxPostCursor;
  logic [47:0] nts0MacAddress;
  logic [31:0] nts0IpAddress;
  int          errCount  = 0;
  int          testCount = 0;
  int          failCount = 0;

  mmioClient u_dut (.*);

  `include "mmioTbTasks.svh"

  initial
  begin
    shlClk = 1'b0;
    forever #50 shlClk = ~shlClk;   // 100 ns period
  end

  // rdValid checks --------------------
  rdValidPulse: assert property (@(posedge shlClk) disable iff (!rstN)
                                 !(rdValid && $past(rdValid)))
    else
    begin
      errCount++;
      $display("ERROR %0t: rdValid stayed high for more than one cycle", $time);
    end

  rdValidReset: assert property (@(posedge shlClk) rstN || !rdValid)
    else
    begin
      errCount++;
      $display("ERROR %0t: rdValid high during reset", $time);
    end

  task automatic checkValue(input string name, input logic [47:0] exp, input logic [47:0] got);
    assert (got === exp)
    else
    begin
      errCount++;
      $display("ERROR %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
    end
  endtask

  task automatic readCheck(input string name, input logic [7:0] a, input logic [7:0] exp);
    logic [7:0] data;
    int         lat;
    busRead(a, ReadTimeout, data, lat);
    if (lat < 0)
    begin
      errCount++;
      $display("ERROR %0t: no rdValid within %0d cycles, read of 0x%h", $time, ReadTimeout, a);
    end
    else
    begin
      checkValue(name, 48'(exp), 48'(data));
      checkValue("rdValid latency", 48'(ReadLatency), 48'(lat));
    end
  endtask

  task automatic endTest(input string name, input int errBefore);
    testCount++;
    if (errCount == errBefore)
      $display("%0t: test %s ok", $time, name);
    else
    begin
      failCount++;
      $display("%0t: test %s FAILED, %0d errors", $time, name, errCount - errBefore);
    end
  endtask

  // Every tuning and loopback port in one word
  function automatic logic [47:0] ctrlPorts();
    return 48'({eth0RxEqualizerMode, eth0TxDriverSwing, eth0TxPreCursor, eth0TxPostCursor,
                eth0PcsLoopbackEn, eth0MacLoopbackEn, eth0MacAddrSwapEn});
  endfunction

  initial
  begin
    logic [7:0]  b [10];   // Random bytes of the current test
    logic [47:0] expMac;
    logic [31:0] expIp;
    logic [47:0] expCtrl;
    logic [7:0]  rd;
    logic [3:0]  stat;
    int          lat;
    int          errBefore;
    void'($urandom(32'hd4ac_3e2b));
    csN    = 1'b1;
    weN    = 1'b1;
    addr   = '0;
    wrData = '0;
    {eth0QpllLock, eth0CoreReady, mc1InitCalComplete, mc0InitCalComplete} = 4'h0;
    rstN = 1'b0;
    repeat (4) @(negedge shlClk);
    rstN = 1'b1;

    // Reset defaults --------------------
    errBefore = errCount;
    checkValue("eth0RxEqualizerMode", 48'(1), 48'(eth0RxEqualizerMode));
    checkValue("eth0TxDriverSwing", 48'(4), 48'(eth0TxDriverSwing));
    checkValue("eth0TxPreCursor", 48'(5), 48'(eth0TxPreCursor));
    checkValue("eth0TxPostCursor", 48'(5), 48'(eth0TxPostCursor));
    checkValue("loopback enables", 48'(0),
               48'({eth0PcsLoopbackEn, eth0MacLoopbackEn, eth0MacAddrSwapEn}));
    checkValue("nts0MacAddress", 48'(0), nts0MacAddress);
    checkValue("nts0IpAddress", 48'(0), 48'(nts0IpAddress));
    readCheck("scratch byte 0", 8'(`DIAG_SCRATCH), 8'hDE);
    readCheck("scratch byte 1", 8'(`DIAG_SCRATCH + 1), 8'hAD);
    readCheck("scratch byte 2", 8'(`DIAG_SCRATCH + 2), 8'hBE);
    readCheck("scratch byte 3", 8'(`DIAG_SCRATCH + 3), 8'hEF);
    endTest("reset defaults", errBefore);

    // MAC and IP ports with the LSB at the lowest address
    errBefore = errCount;
    for (int i = 0; i < 10; i++)
      b[i] = 8'($urandom());
    for (int i = 0; i < 6; i++)
    begin
      busWrite(8'(`LY2_MAC + i), b[i]);
      expMac[i*8 +: 8] = b[i];
    end
    for (int i = 0; i < 4; i++)
    begin
      busWrite(8'(`LY3_IP + i), b[6+i]);
      expIp[i*8 +: 8] = b[6+i];
    end
    checkValue("nts0MacAddress", expMac, nts0MacAddress);
    checkValue("nts0IpAddress", 48'(expIp), 48'(nts0IpAddress));
    endTest("address outputs", errBefore);

    // Tuning, scratch, diag control
    errBefore = errCount;
    for (int i = 0; i < 8; i++)
      b[i] = 8'($urandom());
    for (int i = 0; i < 3; i++)
      busWrite(8'(`PHY_ETH0 + i), b[i]);
    for (int i = 0; i < 4; i++)
      busWrite(8'(`DIAG_SCRATCH + i), b[3+i]);
    busWrite(8'(`DIAG_CTRL), b[7]);
    for (int i = 0; i < 3; i++)
      readCheck("eth0Tuning byte", 8'(`PHY_ETH0 + i), b[i]);   // Reserved bits too
    for (int i = 0; i < 4; i++)
      readCheck("scratch byte", 8'(`DIAG_SCRATCH + i), b[3+i]);
    readCheck("diagCtrl", 8'(`DIAG_CTRL), b[7]);
    checkValue("eth0RxEqualizerMode", 48'(b[0][0]), 48'(eth0RxEqualizerMode));
    checkValue("eth0TxDriverSwing", 48'(b[0][7:4]), 48'(eth0TxDriverSwing));
    checkValue("eth0TxPreCursor", 48'(b[1][4:0]), 48'(eth0TxPreCursor));
    checkValue("eth0TxPostCursor", 48'(b[2][4:0]), 48'(eth0TxPostCursor));
    checkValue("eth0PcsLoopbackEn", 48'(b[7][0]), 48'(eth0PcsLoopbackEn));
    checkValue("eth0MacLoopbackEn", 48'(b[7][1]), 48'(eth0MacLoopbackEn));
    checkValue("eth0MacAddrSwapEn", 48'(b[7][2]), 48'(eth0MacAddrSwapEn));
    endTest("control readback", errBefore);

    // VPD constants, live status, unmapped
    errBefore = errCount;
    for (int i = 0; i < 3; i++)
      busWrite(8'(`VPD_ID + i), 8'($urandom()));
    readCheck("vpdId", 8'(`VPD_ID), 8'h3C);
    readCheck("vpdVer", 8'(`VPD_VER), 8'h01);
    readCheck("vpdRev", 8'(`VPD_REV), 8'h00);
    @(negedge shlClk);
    stat = 4'($urandom());
    {eth0QpllLock, eth0CoreReady, mc1InitCalComplete, mc0InitCalComplete} = stat;
    readCheck("phyStatus", 8'(`PHY_STAT), {4'h0, stat});
    readCheck("unmapped 0x50", 8'h50, 8'h00);
    endTest("read-only and status", errBefore);

    // Upper half aliases of mapped offsets
    errBefore = errCount;
    busRead(8'h90, 4, rd, lat);
    if (lat >= 0)
    begin
      errCount++;
      $display("ERROR %0t: read of upper-half address 0x90 raised rdValid", $time);
    end
    // Fields as last written in the control test
    expCtrl = 48'({b[0][0], b[0][7:4], b[1][4:0], b[2][4:0], b[7][0], b[7][1], b[7][2]});
    busWrite(8'hA2, ~expMac[7:0]);
    busWrite(8'hB4, ~expIp[7:0]);
    busWrite(8'hF4, ~b[7]);
    busWrite(8'h91, ~b[0]);
    checkValue("nts0MacAddress", expMac, nts0MacAddress);
    checkValue("nts0IpAddress", 48'(expIp), 48'(nts0IpAddress));
    checkValue("tuning and loopback ports", expCtrl, ctrlPorts());
    endTest("upper-half accesses", errBefore);

    // Read right behind a write
    errBefore = errCount;
    b[0] = 8'($urandom());
    writeThenRead(8'(`DIAG_SCRATCH + 1), b[0], rd, lat);
    checkValue("rdData after write", 48'(b[0]), 48'(rd));
    checkValue("rdValid latency", 48'(ReadLatency), 48'(lat));
    b[1] = 8'($urandom());
    writeThenRead(8'(`LY3_IP + 2), b[1], rd, lat);
    checkValue("rdData after write", 48'(b[1]), 48'(rd));
    checkValue("rdValid latency", 48'(ReadLatency), 48'(lat));
    endTest("read latency", errBefore);

    $display("Tests: %0d run, %0d failed, %0d errors", testCount, failCount, errCount);
    if (errCount == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  // Hang guard
  initial
  begin
    #(WatchdogNs);
    $display("ERROR %0t: simulation time limit reached", $time);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: flist.f
+incdir+verilog
+incdir+tb
verilog/mmioBusPkg.sv
verilog/mmioRegPkg.sv
verilog/regBusIf.sv
verilog/emifPort.sv
verilog/ctrlReg.sv
verilog/statusReadMux.sv
verilog/mmioClient.sv
tb/tbMmioClient.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the MMIO client testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tbMmioClient -f flist.f -o simMmio
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simMmio > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0
